// File: dv/dcacheTb.sv
`default_nettype none

module dcacheTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxCycles = 20000;

  typedef struct packed {
    logic        isStore;
    logic [31:0] addr;
    logic [63:0] data;
  } expT;

  logic                   clk;
  logic                   rst_n;
  logic                   reqValid_i;
  cacheGeomPkg::cacheReqT req_i;
  logic                   addrOk_o;
  logic                   dataOk_o;
  cacheGeomPkg::cacheRspT rsp_o;
  logic                   memRdValid_o;
  memBusPkg::memRdReqT    memRdReq_o;
  logic                   memRdReady_i;
  logic                   memBeatValid_i;
  memBusPkg::memRdBeatT   memBeat_i;
  logic                   memWrValid_o;
  memBusPkg::memWrReqT    memWrReq_o;
  logic                   memWrReady_i;

  logic [255:0] shadow [256];
  bit           written [256];
  expT          expQ [$];
  integer       seed;
  int           errors = 0;
  int           checks = 0;
  int           cycleCnt = 0;
  int           rdGrants = 0;
  int           lastAcceptCycle = 0;
  logic         acceptedFlag = 1'b0;

  dcacheTop #(
    .NumSets    (64),
    .VictimSeed (8'h5a)
  ) dcacheTop_inst (
    .clk, .rst_n, .reqValid_i, .req_i, .addrOk_o, .dataOk_o, .rsp_o,
    .memRdValid_o, .memRdReq_o, .memRdReady_i, .memBeatValid_i, .memBeat_i,
    .memWrValid_o, .memWrReq_o, .memWrReady_i
  );

  memModel memInst (
    .clk, .rst_n,
    .memRdValid_i   (memRdValid_o),
    .memRdReq_i     (memRdReq_o),
    .memRdReady_o   (memRdReady_i),
    .memBeatValid_o (memBeatValid_i),
    .memBeat_o      (memBeat_i),
    .memWrValid_i   (memWrValid_o),
    .memWrReq_i     (memWrReq_o),
    .memWrReady_o   (memWrReady_i)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= MaxCycles) begin
      $display("timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic expectEq(input logic [255:0] got, input logic [255:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] randAddr(input int sets, input int tags);
    logic [31:0] r;
    r = $random(seed);
    return {19'b0, 2'(r[15:8] % tags), 6'(r[7:2] % sets), r[1:0], 3'b0};
  endfunction

  // samples late in the cycle once the falling-edge drive has settled
  always @(negedge clk) begin : monitor
    expT         e;
    logic [31:0] wa;
    logic [7:0]  idx;
    #3;
    if (rst_n) begin
      if (dataOk_o) begin
        if (expQ.size() == 0) begin
          errors++;
          $display("dataOk_o pulsed at %0d ns with no request outstanding", $time);
        end else begin
          e = expQ.pop_front();
          if (!e.isStore) begin
            expectEq(rsp_o.rData, e.data, "load data");
          end
        end
      end
      if (memRdValid_o && memRdReady_i) begin
        rdGrants++;
        if (expQ.size() != 0) begin
          expectEq(memRdReq_o.lineAddr, {expQ[0].addr[31:5], 5'b0}, "refill address");
        end
      end
      if (memWrValid_o && memWrReady_i) begin
        wa  = memWrReq_o.lineAddr;
        idx = wa[12:5];
        expectEq(wa[31:13], '0, "write-back address range");
        expectEq(memWrReq_o.line, shadow[idx], "write-back line");
        checks++;
        assert (written[idx]) else begin
          errors++;
          $display("write-back at %0d ns of line %h that was never stored to", $time, wa);
        end
      end
      acceptedFlag = reqValid_i && addrOk_o;
      if (acceptedFlag) begin
        lastAcceptCycle = cycleCnt;
        wa  = req_i.addr;
        idx = wa[12:5];
        if (req_i.isStore) begin
          written[idx] = 1'b1;
          for (int b = 0; b < 8; b++) begin
            if (req_i.wMask[b]) begin
              shadow[idx][wa[4:3]*64 + b*8 +: 8] = req_i.wData[b*8 +: 8];
            end
          end
        end
        e.isStore = req_i.isStore;
        e.addr    = wa;
        e.data    = shadow[idx][wa[4:3]*64 +: 64];
        expQ.push_back(e);
      end
    end
  end

  // holds the request until the cache takes it
  task automatic issue(input logic st, input logic [31:0] a, input logic [63:0] d,
                       input logic [7:0] m);
    reqValid_i    = 1'b1;
    req_i.isStore = st;
    req_i.addr    = a;
    req_i.wData   = d;
    req_i.wMask   = m;
    do @(negedge clk); while (!acceptedFlag);
    reqValid_i = 1'b0;
  endtask

  task automatic drain();
    while (expQ.size() != 0) @(negedge clk);
  endtask

  initial begin : main
    logic [31:0] a;
    logic [31:0] r;
    int          firstAcc;
    int          grantsBefore;
    clk        = 1'b0;
    rst_n      = 1'b0;
    reqValid_i = 1'b0;
    req_i      = '0;
    seed       = 32'hccad692d;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = memInst.image[i];
    end
    expectEq({memRdValid_o, memWrValid_o}, '0, "memory strobes after reset");

    // one cold load per set
    for (int s = 0; s < 8; s++) begin
      issue(1'b0, {21'd0, 6'(s), 5'd8}, '0, '0);
    end
    drain();
    expectEq(rdGrants, 8, "refill count over cold loads");

    // repeated hit loads go back to back without a refill
    a = {21'd1, 6'd9, 5'd0};
    issue(1'b0, a, '0, '0);
    drain();
    grantsBefore = rdGrants;
    issue(1'b0, a, '0, '0);
    firstAcc = lastAcceptCycle;
    issue(1'b0, a + 32'd8, '0, '0);
    expectEq(lastAcceptCycle, firstAcc + 1, "accept cycle of second hit load");
    drain();
    expectEq(rdGrants, grantsBefore, "refill count over hit loads");

    // masked stores then loads of the same doubleword
    for (int i = 0; i < 24; i++) begin
      a = randAddr(16, 2);
      r = $random(seed);
      issue(1'b1, a, {$random(seed), $random(seed)}, r[7:0]);
      issue(1'b0, a, '0, '0);
    end
    drain();

    // three lines in one set force evictions
    for (int rep = 0; rep < 3; rep++) begin
      for (int t = 0; t < 3; t++) begin
        r = $random(seed);
        issue(1'b1, {21'(t), 6'd20, r[4:3], 3'b0}, {$random(seed), $random(seed)}, r[15:8]);
      end
      for (int t = 0; t < 3; t++) begin
        r = $random(seed);
        issue(1'b0, {21'(t), 6'd20, r[4:3], 3'b0}, '0, '0);
      end
    end
    drain();

    // random mix over 16 sets with a third tag now and then
    for (int i = 0; i < 2000; i++) begin
      r = $random(seed);
      a = randAddr(16, (r[7:4] == 4'd0) ? 3 : 2);
      issue(r[0], a, {$random(seed), $random(seed)}, r[15:8]);
    end
    drain();

    $display("summary: %0d checks, %0d errors, %0d refills", checks, errors, rdGrants);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/memModel.sv
`default_nettype none

module memModel (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 memRdValid_i,
  input  wire memBusPkg::memRdReqT  memRdReq_i,
  output logic                      memRdReady_o,
  output logic                      memBeatValid_o,
  output memBusPkg::memRdBeatT      memBeat_o,
  input  wire logic                 memWrValid_i,
  input  wire memBusPkg::memWrReqT  memWrReq_i,
  output logic                      memWrReady_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // 8 KB image, 256 lines of 32 bytes, indexed by address bits 12:5
  logic [cacheGeomPkg::LineBits-1:0] image [256];
  integer                            seed;
  logic [cacheGeomPkg::LineBits-1:0] rdLine;
  logic [31:0]                       rnd;

  initial begin
    seed           = 32'hccad692d;
    memRdReady_o   = 1'b0;
    memWrReady_o   = 1'b0;
    memBeatValid_o = 1'b0;
    memBeat_o      = '0;
    for (int i = 0; i < 256; i++) begin
      for (int w = 0; w < 8; w++) begin
        image[i][w*32 +: 32] = $random(seed);
      end
    end
    // outputs change only on the falling edge
    forever begin
      @(negedge clk);
      memRdReady_o   = 1'b0;
      memWrReady_o   = 1'b0;
      memBeatValid_o = 1'b0;
      if (rst_n && memWrValid_i) begin
        rnd = $random(seed);
        repeat (rnd[1:0]) @(negedge clk);
        memWrReady_o = 1'b1;
        image[memWrReq_i.lineAddr[12:5]] = memWrReq_i.line;
      end else if (rst_n && memRdValid_i) begin
        rnd = $random(seed);
        repeat (rnd[1:0]) @(negedge clk);
        memRdReady_o = 1'b1;
        rdLine = image[memRdReq_i.lineAddr[12:5]];
        // four beats in line order, random gaps between them
        for (int b = 0; b < cacheGeomPkg::BeatsPerLine; b++) begin
          @(negedge clk);
          memRdReady_o   = 1'b0;
          memBeatValid_o = 1'b0;
          rnd = $random(seed);
          repeat (rnd[0]) @(negedge clk);
          memBeat_o.data = rdLine[b*cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits];
          memBeat_o.last = (b == cacheGeomPkg::BeatsPerLine - 1);
          memBeatValid_o = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/cacheGeomPkg.sv
`default_nettype none

package cacheGeomPkg;

  // 21-bit tag, 6-bit index, 5-bit offset
  localparam int TagBits      = 21;
  localparam int IndexBits    = 6;
  localparam int OffsetBits   = 5;
  localparam int WordBits     = 64;
  localparam int LineBits     = 256;
  localparam int BeatsPerLine = 4;

  // one data bank holds half a line
  localparam int BankBits     = LineBits / 2;

  typedef struct packed {
    logic [TagBits-1:0]    tag;
    logic [IndexBits-1:0]  index;
    logic [OffsetBits-1:0] offset;
  } cacheAddrT;

  // byte mask arrives already lane aligned
  typedef struct packed {
    logic                  isStore;
    cacheAddrT             addr;
    logic [WordBits-1:0]   wData;
    logic [WordBits/8-1:0] wMask;
  } cacheReqT;

  typedef struct packed {
    logic [WordBits-1:0] rData;
  } cacheRspT;

  // one hit flag per way
  typedef struct packed {
    logic way1;
    logic way0;
  } wayHitT;

endpackage

`default_nettype wire

// File: hdl/dataSram.sv
`default_nettype none

module dataSram #(
  parameter int NumSets = 64
) (
  input  wire logic                                clk,
  input  wire logic                                en_i,
  input  wire logic                                we_i,
  input  wire logic [cacheGeomPkg::IndexBits-1:0]  addr_i,
  input  wire logic [cacheGeomPkg::BankBits-1:0]   wMask_i,
  input  wire logic [cacheGeomPkg::BankBits-1:0]   wData_i,
  output logic      [cacheGeomPkg::BankBits-1:0]   rData_o
);

  logic [cacheGeomPkg::BankBits-1:0] mem [NumSets];

  // bit masked write, read data valid the cycle after
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= (mem[addr_i] & ~wMask_i) | (wData_i & wMask_i);
      end else begin
        rData_o <= mem[addr_i];
      end
    end
  end

  // rData_o holds while the bank is idle

endmodule

`default_nettype wire

// File: hdl/dcacheCore.sv
`default_nettype none

module dcacheCore (
  input  wire logic                                    clk,
  input  wire logic                                    rst_n,
  input  wire logic                                    reqValid_i,
  input  wire cacheGeomPkg::cacheReqT                  req_i,
  output logic                                         addrOk_o,
  output logic                                         dataOk_o,
  output cacheGeomPkg::cacheRspT                       rsp_o,
  output logic      [cacheGeomPkg::IndexBits-1:0]      index_o,
  output logic      [cacheGeomPkg::TagBits-1:0]        tag_o,
  output logic                                         fill_o,
  output logic                                         setDirty_o,
  input  wire cacheGeomPkg::wayHitT                    hitWay_i,
  input  wire logic                                    victim_i,
  input  wire logic                                    victimDirty_i,
  input  wire logic [cacheGeomPkg::TagBits-1:0]        victimTag_i,
  output logic      [3:0]                              bankEn_o,
  output logic      [3:0]                              bankWe_o,
  output logic      [3:0][cacheGeomPkg::IndexBits-1:0] bankAddr_o,
  output logic      [3:0][cacheGeomPkg::BankBits-1:0]  bankMask_o,
  output logic      [3:0][cacheGeomPkg::BankBits-1:0]  bankWData_o,
  input  wire logic [3:0][cacheGeomPkg::BankBits-1:0]  bankRData_i,
  output logic                                         memRdValid_o,
  output memBusPkg::memRdReqT                          memRdReq_o,
  input  wire logic                                    memRdReady_i,
  input  wire logic                                    memBeatValid_i,
  input  wire memBusPkg::memRdBeatT                    memBeat_i,
  output logic                                         memWrValid_o,
  output memBusPkg::memWrReqT                          memWrReq_o,
  input  wire logic                                    memWrReady_i
);

  typedef enum logic [2:0] {
    Idle,
    Compare,
    WriteBack,
    ReadReq,
    Fill,
    Install
  } stateT;

  stateT                                                 stateQ;
  stateT                                                 stateD;
  cacheGeomPkg::cacheReqT                                reqQ;
  logic [cacheGeomPkg::LineBits-1:0]                     fillBufQ;
  logic [$clog2(cacheGeomPkg::BeatsPerLine)-1:0]         beatCntQ;
  logic                                                  fromFillQ;
  logic                                                  inCompare;
  logic                                                  cacheHit;
  logic                                                  accept;
  logic                                                  missRead;
  logic [cacheGeomPkg::LineBits-1:0]                     hitLine;
  logic [cacheGeomPkg::LineBits-1:0]                     loadLine;
  logic [cacheGeomPkg::WordBits-1:0]                     storeMask;
  logic [cacheGeomPkg::BankBits-1:0]                     halfMask;
  logic [3:0]                                            storeWe;
  logic [3:0]                                            installWe;

  assign inCompare = stateQ == Compare;
  assign cacheHit  = hitWay_i.way0 | hitWay_i.way1;

  // a hit store owns the banks this cycle
  assign addrOk_o = (stateQ == Idle) || (inCompare && cacheHit && !reqQ.isStore);
  assign accept   = reqValid_i && addrOk_o;
  assign dataOk_o = inCompare && cacheHit;
  assign missRead = inCompare && !cacheHit;

  // tag store always looks at the latched request
  assign index_o    = reqQ.addr.index;
  assign tag_o      = reqQ.addr.tag;
  assign fill_o     = stateQ == Install;
  assign setDirty_o = inCompare && cacheHit && reqQ.isStore;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      Idle: begin
        if (accept) begin
          stateD = Compare;
        end
      end
      Compare: begin
        if (cacheHit) begin
          stateD = accept ? Compare : Idle;
        end else begin
          stateD = victimDirty_i ? WriteBack : ReadReq;
        end
      end
      WriteBack: begin
        if (memWrReady_i) begin
          stateD = ReadReq;
        end
      end
      ReadReq: begin
        if (memRdReady_i) begin
          stateD = Fill;
        end
      end
      Fill: begin
        if (memBeatValid_i && memBeat_i.last) begin
          stateD = Install;
        end
      end
      Install: stateD = Compare;
      default: stateD = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ    <= Idle;
      beatCntQ  <= '0;
      fromFillQ <= 1'b0;
    end else begin
      stateQ    <= stateD;
      // first compare after install reads from the fill buffer
      fromFillQ <= stateQ == Install;
      if (stateQ == ReadReq) begin
        beatCntQ <= '0;
      end else if (stateQ == Fill && memBeatValid_i) begin
        beatCntQ <= beatCntQ + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i;
    end
    if (stateQ == Fill && memBeatValid_i) begin
      fillBufQ[beatCntQ*cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits] <= memBeat_i.data;
    end
  end

  // load doubleword from the hitting way
  assign hitLine  = hitWay_i.way1 ? {bankRData_i[3], bankRData_i[2]}
                                  : {bankRData_i[1], bankRData_i[0]};
  assign loadLine = fromFillQ ? fillBufQ : hitLine;

  always_comb begin
    rsp_o.rData = loadLine[reqQ.addr.offset[4:3]*cacheGeomPkg::WordBits +:
                           cacheGeomPkg::WordBits];
  end

  // byte mask to bit mask, then into the addressed half
  always_comb begin
    for (int b = 0; b < cacheGeomPkg::WordBits / 8; b++) begin
      storeMask[b*8 +: 8] = {8{reqQ.wMask[b]}};
    end
  end

  assign halfMask = reqQ.addr.offset[3] ? {storeMask, {cacheGeomPkg::WordBits{1'b0}}}
                                        : {{cacheGeomPkg::WordBits{1'b0}}, storeMask};

  // banks: way0 low, way0 high, way1 low, way1 high
  always_comb begin
    storeWe   = '0;
    installWe = victim_i ? 4'b1100 : 4'b0011;
    if (stateQ != Install) begin
      installWe = '0;
    end
    if (setDirty_o) begin
      storeWe[{hitWay_i.way1, reqQ.addr.offset[4]}] = 1'b1;
    end
  end

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bankWe_o[b]   = storeWe[b] | installWe[b];
      // miss in compare reads the victim line for write-back
      bankEn_o[b]   = bankWe_o[b] | accept | missRead;
      bankAddr_o[b] = accept ? req_i.addr.index : reqQ.addr.index;
      bankMask_o[b] = installWe[b] ? '1 : halfMask;
      bankWData_o[b] = installWe[b]
                     ? fillBufQ[(b % 2)*cacheGeomPkg::BankBits +: cacheGeomPkg::BankBits]
                     : {2{reqQ.wData}};
    end
  end

  assign memRdValid_o = stateQ == ReadReq;
  assign memWrValid_o = stateQ == WriteBack;

  always_comb begin
    memRdReq_o.lineAddr        = reqQ.addr;
    memRdReq_o.lineAddr.offset = '0;
    memWrReq_o.lineAddr.tag    = victimTag_i;
    memWrReq_o.lineAddr.index  = reqQ.addr.index;
    memWrReq_o.lineAddr.offset = '0;
    // bank outputs hold the victim line through write-back
    memWrReq_o.line = victim_i ? {bankRData_i[3], bankRData_i[2]}
                               : {bankRData_i[1], bankRData_i[0]};
  end

endmodule

`default_nettype wire

// File: hdl/dcacheTop.sv
`default_nettype none

module dcacheTop #(
  parameter int         NumSets    = 64,
  parameter logic [7:0] VictimSeed = 8'hb5
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   reqValid_i,
  input  wire cacheGeomPkg::cacheReqT req_i,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output cacheGeomPkg::cacheRspT      rsp_o,
  output logic                        memRdValid_o,
  output memBusPkg::memRdReqT         memRdReq_o,
  input  wire logic                   memRdReady_i,
  input  wire logic                   memBeatValid_i,
  input  wire memBusPkg::memRdBeatT   memBeat_i,
  output logic                        memWrValid_o,
  output memBusPkg::memWrReqT         memWrReq_o,
  input  wire logic                   memWrReady_i
);

  logic [cacheGeomPkg::IndexBits-1:0]      tagIndex;
  logic [cacheGeomPkg::TagBits-1:0]        tag;
  logic                                    fill;
  logic                                    setDirty;
  cacheGeomPkg::wayHitT                    hitWay;
  logic                                    victim;
  logic                                    victimDirty;
  logic [cacheGeomPkg::TagBits-1:0]        victimTag;
  logic [3:0]                              bankEn;
  logic [3:0]                              bankWe;
  logic [3:0][cacheGeomPkg::IndexBits-1:0] bankAddr;
  logic [3:0][cacheGeomPkg::BankBits-1:0]  bankMask;
  logic [3:0][cacheGeomPkg::BankBits-1:0]  bankWData;
  logic [3:0][cacheGeomPkg::BankBits-1:0]  bankRData;

  dcacheCore uCore (
    .clk, .rst_n, .reqValid_i, .req_i, .addrOk_o, .dataOk_o, .rsp_o,
    .index_o       (tagIndex),
    .tag_o         (tag),
    .fill_o        (fill),
    .setDirty_o    (setDirty),
    .hitWay_i      (hitWay),
    .victim_i      (victim),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .bankEn_o      (bankEn),
    .bankWe_o      (bankWe),
    .bankAddr_o    (bankAddr),
    .bankMask_o    (bankMask),
    .bankWData_o   (bankWData),
    .bankRData_i   (bankRData),
    .memRdValid_o, .memRdReq_o, .memRdReady_i, .memBeatValid_i, .memBeat_i,
    .memWrValid_o, .memWrReq_o, .memWrReady_i
  );

  tagStore #(
    .NumSets    (NumSets),
    .VictimSeed (VictimSeed)
  ) uTags (
    .clk, .rst_n,
    .index_i       (tagIndex),
    .tag_i         (tag),
    .fill_i        (fill),
    .setDirty_i    (setDirty),
    .hitWay_o      (hitWay),
    .victim_o      (victim),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  // way0 low, way0 high, way1 low, way1 high
  for (genvar b = 0; b < 4; b++) begin : gBank
    dataSram #(
      .NumSets (NumSets)
    ) uBank (
      .clk,
      .en_i    (bankEn[b]),
      .we_i    (bankWe[b]),
      .addr_i  (bankAddr[b]),
      .wMask_i (bankMask[b]),
      .wData_i (bankWData[b]),
      .rData_o (bankRData[b])
    );
  end

endmodule

`default_nettype wire

// File: hdl/memBusPkg.sv
`default_nettype none

package memBusPkg;

  // line aligned, offset bits are zero
  typedef struct packed {
    cacheGeomPkg::cacheAddrT lineAddr;
  } memRdReqT;

  // refill beats come back in line order
  typedef struct packed {
    logic [cacheGeomPkg::WordBits-1:0] data;
    logic                              last;
  } memRdBeatT;

  // whole dirty line in one transfer
  typedef struct packed {
    cacheGeomPkg::cacheAddrT           lineAddr;
    logic [cacheGeomPkg::LineBits-1:0] line;
  } memWrReqT;

endpackage

`default_nettype wire

// File: hdl/tagStore.sv
`default_nettype none

module tagStore #(
  parameter int         NumSets    = 64,
  parameter logic [7:0] VictimSeed = 8'hb5
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic [cacheGeomPkg::IndexBits-1:0]  index_i,
  input  wire logic [cacheGeomPkg::TagBits-1:0]    tag_i,
  input  wire logic                                fill_i,
  input  wire logic                                setDirty_i,
  output cacheGeomPkg::wayHitT                     hitWay_o,
  output logic                                     victim_o,
  output logic                                     victimDirty_o,
  output logic      [cacheGeomPkg::TagBits-1:0]    victimTag_o
);

  logic [cacheGeomPkg::TagBits-1:0] tagMem [2][NumSets];
  logic [1:0][NumSets-1:0]          validQ;
  logic [1:0][NumSets-1:0]          dirtyQ;
  logic [7:0]                       lfsrQ;
  logic [cacheGeomPkg::TagBits-1:0] tagRd [2];
  cacheGeomPkg::wayHitT             hit;

  // combinational lookup of both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      tagRd[w] = tagMem[w][index_i];
    end
    hit.way0 = validQ[0][index_i] && (tagRd[0] == tag_i);
    hit.way1 = validQ[1][index_i] && (tagRd[1] == tag_i);
  end

  assign hitWay_o = hit;

  // victim way stays fixed until the next fill
  assign victim_o      = lfsrQ[0];
  assign victimDirty_o = dirtyQ[victim_o][index_i];
  assign victimTag_o   = tagRd[victim_o];

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tagMem[victim_o][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
    end else if (fill_i) begin
      // freshly installed line is clean
      validQ[victim_o][index_i] <= 1'b1;
      dirtyQ[victim_o][index_i] <= 1'b0;
    end else if (setDirty_i) begin
      if (hit.way0) begin
        dirtyQ[0][index_i] <= 1'b1;
      end
      if (hit.way1) begin
        dirtyQ[1][index_i] <= 1'b1;
      end
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1, steps once per fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsrQ <= VictimSeed;
    end else if (fill_i) begin
      lfsrQ <= {lfsrQ[6:0], lfsrQ[7] ^ lfsrQ[5] ^ lfsrQ[4] ^ lfsrQ[3]};
    end
  end

endmodule

`default_nettype wire

// File: list.f
hdl/cacheGeomPkg.sv
hdl/memBusPkg.sv
hdl/dataSram.sv
hdl/tagStore.sv
hdl/dcacheCore.sv
hdl/dcacheTop.sv
dv/memModel.sv
dv/dcacheTb.sv

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module dcacheTb \
  -f list.f \
  -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
exit 1
